/* common/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Datapath widths
`define LSU_XLEN       64
`define LSU_PADDR_W    32
`define LSU_RNID_W     6
`define LSU_IMM_W      12

// Access geometry
`define LSU_LINE_BYTES 16
`define LSU_DW_BYTES   (`LSU_XLEN / 8)

// Offset widths within a line and within a doubleword
`define LSU_LINE_OFF_W $clog2(`LSU_LINE_BYTES)
`define LSU_DW_OFF_W   $clog2(`LSU_DW_BYTES)

`endif

/* common/lsu_pkg.sv */
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0]              xlen_t;
  typedef logic [`LSU_PADDR_W-1:0]           paddr_t;
  typedef logic [`LSU_RNID_W-1:0]            rnid_t;
  typedef logic signed [`LSU_IMM_W-1:0]      imm_t;
  typedef logic [`LSU_DW_BYTES-1:0]          byte_mask_t;  // One bit per byte of a doubleword
  typedef logic [`LSU_LINE_BYTES*8-1:0]      line_t;

  // ----------------------------
  // Operation encodings
  // ----------------------------
  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } lsu_op_e;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_DW
  } lsu_size_e;

  typedef enum logic [1:0] {
    EXC_NONE,
    EXC_LD_MISALIGN,
    EXC_ST_MISALIGN
  } except_e;

endpackage

`default_nettype wire

/* common/lsu_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One in-flight operation between two adjacent stages
interface lsu_stage_if;
  import lsu_pkg::*;

  logic      valid;
  lsu_op_e   op;
  lsu_size_e size;
  logic      sign;         // Sign-extend load result
  logic      rd_valid;
  rnid_t     rd_rnid;
  paddr_t    paddr;
  except_e   except_code;

  modport source (
    output valid, op, size, sign,
    output rd_valid, rd_rnid,
    output paddr, except_code
  );

  modport sink (
    input valid, op, size, sign,
    input rd_valid, rd_rnid,
    input paddr, except_code
  );

endinterface

`default_nettype wire

/* design/lsu_agen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_agen (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  input  wire                        i_issue_valid,
  input  wire lsu_pkg::lsu_op_e      i_issue_op,
  input  wire lsu_pkg::lsu_size_e    i_issue_size,
  input  wire                        i_issue_sign,
  input  wire lsu_pkg::xlen_t        i_issue_rs1,
  input  wire lsu_pkg::imm_t         i_issue_imm,
  input  wire                        i_issue_rd_valid,
  input  wire lsu_pkg::rnid_t        i_issue_rd_rnid,
  output logic                       o_l1d_rd_valid,
  output lsu_pkg::paddr_t            o_l1d_rd_paddr,
  lsu_stage_if.source                ex2_out
);
  import lsu_pkg::*;

  // EX0 issue register
  logic      r_ex0_valid;
  lsu_op_e   r_ex0_op;
  lsu_size_e r_ex0_size;
  logic      r_ex0_sign;
  paddr_t    r_ex0_base;    // Bare mode, only the low address bits matter
  imm_t      r_ex0_imm;
  logic      r_ex0_rd_valid;
  rnid_t     r_ex0_rd_rnid;

  // EX1 register
  logic      r_ex1_valid;
  lsu_op_e   r_ex1_op;
  lsu_size_e r_ex1_size;
  logic      r_ex1_sign;
  paddr_t    r_ex1_base;
  imm_t      r_ex1_imm;
  logic      r_ex1_rd_valid;
  rnid_t     r_ex1_rd_rnid;

  paddr_t    w_ex1_paddr;
  logic      w_ex1_misalign;
  except_e   w_ex1_except;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid   <= 1'b0;
      r_ex1_valid   <= 1'b0;
      ex2_out.valid <= 1'b0;
    end else begin
      r_ex0_valid   <= i_issue_valid;
      r_ex1_valid   <= r_ex0_valid;
      ex2_out.valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_op       <= i_issue_op;
    r_ex0_size     <= i_issue_size;
    r_ex0_sign     <= i_issue_sign;
    r_ex0_base     <= i_issue_rs1[`LSU_PADDR_W-1:0];
    r_ex0_imm      <= i_issue_imm;
    r_ex0_rd_valid <= i_issue_rd_valid;
    r_ex0_rd_rnid  <= i_issue_rd_rnid;

    r_ex1_op       <= r_ex0_op;
    r_ex1_size     <= r_ex0_size;
    r_ex1_sign     <= r_ex0_sign;
    r_ex1_base     <= r_ex0_base;
    r_ex1_imm      <= r_ex0_imm;
    r_ex1_rd_valid <= r_ex0_rd_valid;
    r_ex1_rd_rnid  <= r_ex0_rd_rnid;

    ex2_out.op          <= r_ex1_op;
    ex2_out.size        <= r_ex1_size;
    ex2_out.sign        <= r_ex1_sign;
    ex2_out.rd_valid    <= r_ex1_rd_valid;
    ex2_out.rd_rnid     <= r_ex1_rd_rnid;
    ex2_out.paddr       <= w_ex1_paddr;
    ex2_out.except_code <= w_ex1_except;
  end

  // ----------------------------
  // EX1 address generation
  // ----------------------------
  assign w_ex1_paddr = r_ex1_base +
                       {{(`LSU_PADDR_W-`LSU_IMM_W){r_ex1_imm[`LSU_IMM_W-1]}}, r_ex1_imm};

  always_comb begin
    case (r_ex1_size)
      SIZE_B:  w_ex1_misalign = 1'b0;
      SIZE_H:  w_ex1_misalign = w_ex1_paddr[0];
      SIZE_W:  w_ex1_misalign = |w_ex1_paddr[1:0];
      default: w_ex1_misalign = |w_ex1_paddr[2:0];
    endcase
  end

  assign w_ex1_except = !w_ex1_misalign     ? EXC_NONE :
                        r_ex1_op == OP_LOAD ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;

  // Only aligned loads touch the cache
  assign o_l1d_rd_valid = r_ex1_valid & (r_ex1_op == OP_LOAD) & !w_ex1_misalign;
  assign o_l1d_rd_paddr = {w_ex1_paddr[`LSU_PADDR_W-1:`LSU_LINE_OFF_W],
                           {(`LSU_LINE_OFF_W){1'b0}}};

endmodule

`default_nettype wire

/* design/lsu_load_data.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_load_data (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  lsu_stage_if.sink                  ex2_in,
  input  wire                        i_l1d_hit,
  input  wire lsu_pkg::line_t        i_l1d_line,
  output logic                       o_fwd_valid,
  output lsu_pkg::paddr_t            o_fwd_paddr,
  output lsu_pkg::lsu_size_e         o_fwd_size,
  input  wire lsu_pkg::byte_mask_t   i_fwd_mask,
  input  wire lsu_pkg::xlen_t        i_fwd_data,
  output logic                       o_miss_valid,
  output lsu_pkg::paddr_t            o_miss_paddr,
  output lsu_pkg::xlen_t             o_ex2_data,
  lsu_stage_if.source                ex3_out
);
  import lsu_pkg::*;

  logic       w_ex2_load;
  xlen_t      w_l1d_dw;
  xlen_t      w_merged;
  xlen_t      w_shifted;
  byte_mask_t w_size_mask;
  byte_mask_t w_need;
  logic       w_complete;

  // Aligned loads only, these are the ones that read the cache
  assign w_ex2_load = ex2_in.valid & (ex2_in.op == OP_LOAD) &
                      (ex2_in.except_code == EXC_NONE);

  assign o_fwd_valid = w_ex2_load;
  assign o_fwd_paddr = ex2_in.paddr;
  assign o_fwd_size  = ex2_in.size;

  // ----------------------------
  // Byte merge
  // ----------------------------
  assign w_l1d_dw = i_l1d_line[{ex2_in.paddr[`LSU_LINE_OFF_W-1:`LSU_DW_OFF_W],
                                {($clog2(`LSU_XLEN)){1'b0}}} +: `LSU_XLEN];

  for (genvar b = 0; b < `LSU_DW_BYTES; b++) begin : g_byte
    assign w_merged[b*8 +: 8] = i_fwd_mask[b] ? i_fwd_data[b*8 +: 8] : w_l1d_dw[b*8 +: 8];
  end

  always_comb begin
    case (ex2_in.size)
      SIZE_B:  w_size_mask = 8'h01;
      SIZE_H:  w_size_mask = 8'h03;
      SIZE_W:  w_size_mask = 8'h0f;
      default: w_size_mask = 8'hff;
    endcase
  end

  assign w_need     = w_size_mask << ex2_in.paddr[`LSU_DW_OFF_W-1:0];
  assign w_complete = i_l1d_hit | (&(i_fwd_mask | ~w_need));  // Hit or all bytes forwarded

  assign o_miss_valid = w_ex2_load & !w_complete;
  assign o_miss_paddr = {ex2_in.paddr[`LSU_PADDR_W-1:`LSU_LINE_OFF_W],
                         {(`LSU_LINE_OFF_W){1'b0}}};

  // Align and extend
  assign w_shifted = w_merged >> {ex2_in.paddr[`LSU_DW_OFF_W-1:0], 3'b000};

  always_comb begin
    case (ex2_in.size)
      SIZE_B:  o_ex2_data = {{(`LSU_XLEN-8){ex2_in.sign & w_shifted[7]}}, w_shifted[7:0]};
      SIZE_H:  o_ex2_data = {{(`LSU_XLEN-16){ex2_in.sign & w_shifted[15]}}, w_shifted[15:0]};
      SIZE_W:  o_ex2_data = {{(`LSU_XLEN-32){ex2_in.sign & w_shifted[31]}}, w_shifted[31:0]};
      default: o_ex2_data = w_shifted;
    endcase
  end

  // ----------------------------
  // EX3 register
  // ----------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      ex3_out.valid <= 1'b0;
    end else begin
      ex3_out.valid <= ex2_in.valid & !o_miss_valid;  // Missed loads leave the pipe here
    end
  end

  always_ff @(posedge i_clk) begin
    ex3_out.op          <= ex2_in.op;
    ex3_out.size        <= ex2_in.size;
    ex3_out.sign        <= ex2_in.sign;
    ex3_out.rd_valid    <= ex2_in.rd_valid;
    ex3_out.rd_rnid     <= ex2_in.rd_rnid;
    ex3_out.paddr       <= ex2_in.paddr;
    ex3_out.except_code <= ex2_in.except_code;
  end

endmodule

`default_nettype wire

/* design/lsu_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_top (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  // Issue
  input  wire                        i_issue_valid,
  input  wire lsu_pkg::lsu_op_e      i_issue_op,
  input  wire lsu_pkg::lsu_size_e    i_issue_size,
  input  wire                        i_issue_sign,
  input  wire lsu_pkg::xlen_t        i_issue_rs1,
  input  wire lsu_pkg::imm_t         i_issue_imm,
  input  wire                        i_issue_rd_valid,
  input  wire lsu_pkg::rnid_t        i_issue_rd_rnid,
  // L1D read
  output logic                       o_l1d_rd_valid,
  output lsu_pkg::paddr_t            o_l1d_rd_paddr,
  input  wire                        i_l1d_hit,
  input  wire lsu_pkg::line_t        i_l1d_line,
  // Store queue forwarding
  output logic                       o_fwd_valid,
  output lsu_pkg::paddr_t            o_fwd_paddr,
  output lsu_pkg::lsu_size_e         o_fwd_size,
  input  wire lsu_pkg::byte_mask_t   i_fwd_mask,
  input  wire lsu_pkg::xlen_t        i_fwd_data,
  // Miss, completion and writeback
  output logic                       o_miss_valid,
  output lsu_pkg::paddr_t            o_miss_paddr,
  output logic                       o_done_valid,
  output lsu_pkg::paddr_t            o_done_paddr,
  output lsu_pkg::except_e           o_done_except,
  output logic                       o_wb_valid,
  output lsu_pkg::rnid_t             o_wb_rnid,
  output lsu_pkg::xlen_t             o_wb_data
);
  import lsu_pkg::*;

  lsu_stage_if ex1_to_ex2 ();
  lsu_stage_if ex2_to_ex3 ();

  xlen_t w_ex2_data;

  lsu_agen u_agen (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid),
    .i_issue_op       (i_issue_op),
    .i_issue_size     (i_issue_size),
    .i_issue_sign     (i_issue_sign),
    .i_issue_rs1      (i_issue_rs1),
    .i_issue_imm      (i_issue_imm),
    .i_issue_rd_valid (i_issue_rd_valid),
    .i_issue_rd_rnid  (i_issue_rd_rnid),
    .o_l1d_rd_valid   (o_l1d_rd_valid),
    .o_l1d_rd_paddr   (o_l1d_rd_paddr),
    .ex2_out          (ex1_to_ex2.source)
  );

  lsu_load_data u_load_data (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .ex2_in       (ex1_to_ex2.sink),
    .i_l1d_hit    (i_l1d_hit),
    .i_l1d_line   (i_l1d_line),
    .o_fwd_valid  (o_fwd_valid),
    .o_fwd_paddr  (o_fwd_paddr),
    .o_fwd_size   (o_fwd_size),
    .i_fwd_mask   (i_fwd_mask),
    .i_fwd_data   (i_fwd_data),
    .o_miss_valid (o_miss_valid),
    .o_miss_paddr (o_miss_paddr),
    .o_ex2_data   (w_ex2_data),
    .ex3_out      (ex2_to_ex3.source)
  );

  lsu_writeback u_writeback (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .ex3_in        (ex2_to_ex3.sink),
    .i_ex2_data    (w_ex2_data),
    .o_done_valid  (o_done_valid),
    .o_done_paddr  (o_done_paddr),
    .o_done_except (o_done_except),
    .o_wb_valid    (o_wb_valid),
    .o_wb_rnid     (o_wb_rnid),
    .o_wb_data     (o_wb_data)
  );

endmodule

`default_nettype wire

/* design/lsu_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_writeback (
  input  wire                        i_clk,
  input  wire                        i_reset_n,
  lsu_stage_if.sink                  ex3_in,
  input  wire lsu_pkg::xlen_t        i_ex2_data,
  output logic                       o_done_valid,
  output lsu_pkg::paddr_t            o_done_paddr,
  output lsu_pkg::except_e           o_done_except,
  output logic                       o_wb_valid,
  output lsu_pkg::rnid_t             o_wb_rnid,
  output lsu_pkg::xlen_t             o_wb_data
);
  import lsu_pkg::*;

  xlen_t r_ex3_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_data <= '0;
    end else begin
      r_ex3_data <= i_ex2_data;
    end
  end

  // Everything that survived EX2 completes
  assign o_done_valid  = ex3_in.valid;
  assign o_done_paddr  = ex3_in.paddr;
  assign o_done_except = ex3_in.except_code;

  // Register write, x0 never written
  assign o_wb_valid = ex3_in.valid & (ex3_in.op == OP_LOAD) &
                      (ex3_in.except_code == EXC_NONE) &
                      ex3_in.rd_valid & (ex3_in.rd_rnid != '0);
  assign o_wb_rnid  = ex3_in.rd_rnid;
  assign o_wb_data  = r_ex3_data;

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/lsu_pkg.sv
common/lsu_stage_if.sv
design/lsu_agen.sv
design/lsu_load_data.sv
design/lsu_writeback.sv
design/lsu_pipe_top.sv
verification/tb_lsu_pipe.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_lsu_pipe \
  -Mdir "$BUILD_DIR" -o sim_lsu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_lsu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $LOG"
exit 1

/* verification/tb_lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipe;
  import lsu_pkg::*;

  localparam int CLK_PERIOD = 20;
  // 24 operations of about 8 cycles each plus reset fit well inside
  localparam int MAX_CYCLES = 2000;

  logic       clk;
  logic       reset_n;
  logic       issue_valid;
  lsu_op_e    issue_op;
  lsu_size_e  issue_size;
  logic       issue_sign;
  xlen_t      issue_rs1;
  imm_t       issue_imm;
  logic       issue_rd_valid;
  rnid_t      issue_rd_rnid;
  logic       l1d_rd_valid;
  paddr_t     l1d_rd_paddr;
  logic       l1d_hit;
  line_t      l1d_line;
  logic       fwd_valid;
  paddr_t     fwd_paddr;
  lsu_size_e  fwd_size;
  byte_mask_t fwd_mask;
  xlen_t      fwd_data;
  logic       miss_valid;
  paddr_t     miss_paddr;
  logic       done_valid;
  paddr_t     done_paddr;
  except_e    done_except;
  logic       wb_valid;
  rnid_t      wb_rnid;
  xlen_t      wb_data;

  int cyc;
  int n_tests;
  int n_checks;
  int n_errors;
  int test_errors;

  // Direct-mapped cache model indexed by paddr[7:4]
  line_t       cache_data    [16];
  logic [23:0] cache_tag     [16];
  logic        cache_present [16];
  logic        rd_pend;
  paddr_t      rd_pend_addr;

  // Single store-queue entry
  logic       sq_en;
  paddr_t     sq_addr;
  byte_mask_t sq_mask;
  xlen_t      sq_data;

  // Expected results per issue slot
  paddr_t    exp_paddr [4];
  lsu_size_e exp_size  [4];
  except_e   exp_exc   [4];
  logic      exp_rd    [4];
  logic      exp_miss  [4];
  logic      exp_wb    [4];
  rnid_t     exp_rnid  [4];
  xlen_t     exp_data  [4];
  int        iss_cyc   [4];

  // Observed events
  int        rd_cyc[$];
  paddr_t    rd_addr[$];
  int        fwd_cyc[$];
  paddr_t    fwd_addr[$];
  lsu_size_e fwd_size_q[$];
  int        miss_cyc[$];
  paddr_t    miss_addr[$];
  int        done_cyc[$];
  paddr_t    done_addr[$];
  except_e   done_exc[$];
  int        wb_cyc[$];
  rnid_t     wb_rnid_q[$];
  xlen_t     wb_data_q[$];

  lsu_pipe_top dut_i (
    .i_clk            (clk),
    .i_reset_n        (reset_n),
    .i_issue_valid    (issue_valid),
    .i_issue_op       (issue_op),
    .i_issue_size     (issue_size),
    .i_issue_sign     (issue_sign),
    .i_issue_rs1      (issue_rs1),
    .i_issue_imm      (issue_imm),
    .i_issue_rd_valid (issue_rd_valid),
    .i_issue_rd_rnid  (issue_rd_rnid),
    .o_l1d_rd_valid   (l1d_rd_valid),
    .o_l1d_rd_paddr   (l1d_rd_paddr),
    .i_l1d_hit        (l1d_hit),
    .i_l1d_line       (l1d_line),
    .o_fwd_valid      (fwd_valid),
    .o_fwd_paddr      (fwd_paddr),
    .o_fwd_size       (fwd_size),
    .i_fwd_mask       (fwd_mask),
    .i_fwd_data       (fwd_data),
    .o_miss_valid     (miss_valid),
    .o_miss_paddr     (miss_paddr),
    .o_done_valid     (done_valid),
    .o_done_paddr     (done_paddr),
    .o_done_except    (done_except),
    .o_wb_valid       (wb_valid),
    .o_wb_rnid        (wb_rnid),
    .o_wb_data        (wb_data)
  );

  // ------------------------------
  // Clock, cycle count, models
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cyc = 0;
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc = cyc + 1;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cyc);
    $display("Checks failed");
    $finish;
  end

  // Store queue answers in the same cycle
  assign fwd_mask = (fwd_valid && sq_en && fwd_paddr[31:3] == sq_addr[31:3]) ? sq_mask : '0;
  assign fwd_data = sq_data;

  // Cache answers one cycle after the read
  initial begin
    l1d_hit  = 1'b0;
    l1d_line = '0;
    forever begin
      @(posedge clk);
      #1;
      l1d_hit  = rd_pend && cache_present[rd_pend_addr[7:4]] &&
                 cache_tag[rd_pend_addr[7:4]] == rd_pend_addr[31:8];
      l1d_line = cache_data[rd_pend_addr[7:4]];
    end
  end

  // Mid-cycle sampling of all DUT events
  initial begin
    rd_pend      = 1'b0;
    rd_pend_addr = '0;
    forever begin
      @(negedge clk);
      rd_pend      = l1d_rd_valid;
      rd_pend_addr = l1d_rd_paddr;
      if (l1d_rd_valid) begin
        rd_cyc.push_back(cyc);
        rd_addr.push_back(l1d_rd_paddr);
      end
      if (fwd_valid) begin
        fwd_cyc.push_back(cyc);
        fwd_addr.push_back(fwd_paddr);
        fwd_size_q.push_back(fwd_size);
      end
      if (miss_valid) begin
        miss_cyc.push_back(cyc);
        miss_addr.push_back(miss_paddr);
      end
      if (done_valid) begin
        done_cyc.push_back(cyc);
        done_addr.push_back(done_paddr);
        done_exc.push_back(done_except);
      end
      if (wb_valid) begin
        wb_cyc.push_back(cyc);
        wb_rnid_q.push_back(wb_rnid);
        wb_data_q.push_back(wb_data);
      end
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic paddr_t sext_imm(input imm_t imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic paddr_t line_addr(input paddr_t a);
    return {a[31:4], 4'h0};
  endfunction

  function automatic paddr_t rand_addr(input int sz);
    paddr_t a;
    a = $urandom;
    return a & ~paddr_t'((1 << sz) - 1);  // Aligned to 2**sz bytes
  endfunction

  function automatic rnid_t rand_rd();
    return rnid_t'($urandom_range(63, 1));
  endfunction

  task automatic report_error(input string msg);
    n_errors++;
    test_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors++;
      $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic expect_cycle(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      test_errors++;
      $display("Fail at %0t ns: %s in cycle %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("Test %s, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic fill_line(input paddr_t a, input logic present);
    cache_tag[a[7:4]]     = a[31:8];
    cache_present[a[7:4]] = present;
    cache_data[a[7:4]]    = {$urandom, $urandom, $urandom, $urandom};
  endtask

  task automatic set_sq(input paddr_t a, input byte_mask_t mask);
    sq_en   = 1'b1;
    sq_addr = a;
    sq_mask = mask;
    sq_data = {$urandom, $urandom};
  endtask

  // Expected outcome of one operation from the address, cache and store-queue rules
  task automatic predict(input int slot, input lsu_op_e op, input lsu_size_e size,
                         input logic sign, input xlen_t rs1, input imm_t imm, input rnid_t rd);
    paddr_t a;
    paddr_t ba;
    int     nbytes;
    int     i;
    logic   mis;
    logic   hit;
    logic   all_fwd;
    logic   fwd_hit;
    xlen_t  raw;
    begin
      a       = rs1[31:0] + sext_imm(imm);
      nbytes  = 1 << size;
      mis     = (a % nbytes) != 0;
      hit     = cache_present[a[7:4]] && cache_tag[a[7:4]] == a[31:8];
      all_fwd = 1'b1;
      raw     = '0;
      for (i = 0; i < nbytes; i++) begin
        ba      = a + paddr_t'(i);
        fwd_hit = sq_en && ba[31:3] == sq_addr[31:3] && sq_mask[ba[2:0]];
        if (!fwd_hit) all_fwd = 1'b0;
        raw[i*8 +: 8] = fwd_hit ? sq_data[{ba[2:0], 3'b000} +: 8] :
                                  cache_data[ba[7:4]][{ba[3:0], 3'b000} +: 8];
      end
      if (sign && raw[nbytes*8-1]) begin
        for (i = nbytes; i < 8; i++) raw[i*8 +: 8] = 8'hff;
      end
      exp_paddr[slot] = a;
      exp_size[slot]  = size;
      exp_exc[slot]   = !mis ? EXC_NONE : (op == OP_LOAD ? EXC_LD_MISALIGN : EXC_ST_MISALIGN);
      exp_rd[slot]    = (op == OP_LOAD) && !mis;
      exp_miss[slot]  = exp_rd[slot] && !(hit || all_fwd);
      exp_wb[slot]    = exp_rd[slot] && !exp_miss[slot] && rd != '0;
      exp_rnid[slot]  = rd;
      exp_data[slot]  = raw;
    end
  endtask

  task automatic issue(input int slot, input lsu_op_e op, input lsu_size_e size,
                       input logic sign, input xlen_t rs1, input imm_t imm, input rnid_t rd);
    predict(slot, op, size, sign, rs1, imm, rd);
    issue_valid    = 1'b1;
    issue_op       = op;
    issue_size     = size;
    issue_sign     = sign;
    issue_rs1      = rs1;
    issue_imm      = imm;
    issue_rd_valid = (op == OP_LOAD);
    issue_rd_rnid  = rd;
    @(posedge clk);
    #1;
    issue_valid   = 1'b0;
    iss_cyc[slot] = cyc;  // Edge that captured the issue
  endtask

  // Let the pipe empty, then match events against the expected slots
  task automatic drain_and_check(input int n);
    int s;
    begin
      repeat (6) @(posedge clk);
      #1;
      for (s = 0; s < n; s++) begin
        if (exp_rd[s]) begin
          if (rd_cyc.size() == 0) begin
            report_error($sformatf("operation %0d made no cache read", s));
          end else begin
            expect_cycle("o_l1d_rd_valid", rd_cyc.pop_front(), iss_cyc[s] + 1);
            expect_value("o_l1d_rd_paddr", 64'(rd_addr.pop_front()),
                         64'(line_addr(exp_paddr[s])));
          end
          if (fwd_cyc.size() == 0) begin
            report_error($sformatf("load %0d asked for no forwarding", s));
          end else begin
            expect_cycle("o_fwd_valid", fwd_cyc.pop_front(), iss_cyc[s] + 2);
            expect_value("o_fwd_paddr", 64'(fwd_addr.pop_front()), 64'(exp_paddr[s]));
            expect_value("o_fwd_size", 64'(fwd_size_q.pop_front()), 64'(exp_size[s]));
          end
        end
        if (exp_miss[s]) begin
          if (miss_cyc.size() == 0) begin
            report_error($sformatf("operation %0d raised no miss request", s));
          end else begin
            expect_cycle("o_miss_valid", miss_cyc.pop_front(), iss_cyc[s] + 2);
            expect_value("o_miss_paddr", 64'(miss_addr.pop_front()),
                         64'(line_addr(exp_paddr[s])));
          end
        end else if (done_cyc.size() == 0) begin
          report_error($sformatf("operation %0d never completed", s));
        end else begin
          expect_cycle("o_done_valid", done_cyc.pop_front(), iss_cyc[s] + 3);
          expect_value("o_done_paddr", 64'(done_addr.pop_front()), 64'(exp_paddr[s]));
          expect_value("o_done_except", 64'(done_exc.pop_front()), 64'(exp_exc[s]));
        end
        if (exp_wb[s]) begin
          if (wb_cyc.size() == 0) begin
            report_error($sformatf("load %0d wrote no register", s));
          end else begin
            expect_cycle("o_wb_valid", wb_cyc.pop_front(), iss_cyc[s] + 3);
            expect_value("o_wb_rnid", 64'(wb_rnid_q.pop_front()), 64'(exp_rnid[s]));
            expect_value("o_wb_data", wb_data_q.pop_front(), exp_data[s]);
          end
        end
      end
      if (rd_cyc.size() != 0 || fwd_cyc.size() != 0 || miss_cyc.size() != 0 ||
          done_cyc.size() != 0 || wb_cyc.size() != 0) begin
        report_error("unexpected cache read, forward, miss, completion or writeback");
      end
      rd_cyc.delete();
      rd_addr.delete();
      fwd_cyc.delete();
      fwd_addr.delete();
      fwd_size_q.delete();
      miss_cyc.delete();
      miss_addr.delete();
      done_cyc.delete();
      done_addr.delete();
      done_exc.delete();
      wb_cyc.delete();
      wb_rnid_q.delete();
      wb_data_q.delete();
    end
  endtask

  task automatic run_at(input lsu_op_e op, input lsu_size_e size, input logic sign,
                        input paddr_t a);
    imm_t imm;
    begin
      imm = imm_t'($urandom);
      issue(0, op, size, sign, {$urandom, a - sext_imm(imm)}, imm, rand_rd());
      drain_and_check(1);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic check_reset();
    repeat (9) @(posedge clk);
    @(negedge clk);
    expect_value("o_l1d_rd_valid", 64'(l1d_rd_valid), 64'h0);
    expect_value("o_fwd_valid", 64'(fwd_valid), 64'h0);
    expect_value("o_miss_valid", 64'(miss_valid), 64'h0);
    expect_value("o_done_valid", 64'(done_valid), 64'h0);
    expect_value("o_wb_valid", 64'(wb_valid), 64'h0);
    @(posedge clk);
    #1;
    reset_n = 1'b1;
    end_test("reset");
  endtask

  task automatic test_cache_loads();
    int     sz;
    int     sg;
    paddr_t a;
    begin
      for (sz = 0; sz < 4; sz++) begin
        for (sg = 0; sg < 2; sg++) begin
          a = rand_addr(sz);
          fill_line(a, 1'b1);
          run_at(OP_LOAD, lsu_size_e'(sz), sg[0], a);
        end
      end
      end_test("cache loads");
    end
  endtask

  task automatic test_stores();
    paddr_t a;
    begin
      a = rand_addr(3);
      fill_line(a, 1'b1);
      run_at(OP_STORE, SIZE_DW, 1'b0, a);
      run_at(OP_STORE, SIZE_B, 1'b0, rand_addr(0));
      end_test("stores");
    end
  endtask

  task automatic test_misalign();
    paddr_t a;
    begin
      a = rand_addr(3);
      fill_line(a, 1'b1);
      run_at(OP_LOAD, SIZE_H, 1'b0, a + 32'd1);
      run_at(OP_LOAD, SIZE_W, 1'b1, a + 32'd2);
      run_at(OP_LOAD, SIZE_DW, 1'b0, a + 32'd4);
      run_at(OP_STORE, SIZE_W, 1'b0, a + 32'd3);
      run_at(OP_STORE, SIZE_DW, 1'b0, a + 32'd1);
      end_test("misalign");
    end
  endtask

  task automatic test_forwarding();
    paddr_t a;
    begin
      a = rand_addr(3);
      fill_line(a, 1'b0);
      set_sq(a, 8'hff);  // Full forward on a miss
      run_at(OP_LOAD, SIZE_DW, 1'b0, a);
      set_sq(a, 8'hf0);  // Only the upper word is needed
      run_at(OP_LOAD, SIZE_W, 1'b1, a + 32'd4);
      fill_line(a, 1'b1);
      set_sq(a, 8'h5a);  // Partial forward on a hit
      run_at(OP_LOAD, SIZE_DW, 1'b0, a);
      a = rand_addr(3);
      fill_line(a, 1'b0);
      set_sq(a, 8'h0f);  // Partial forward on a miss
      run_at(OP_LOAD, SIZE_DW, 1'b0, a);
      sq_en = 1'b0;
      end_test("forwarding");
    end
  endtask

  task automatic test_back_to_back();
    paddr_t a;
    paddr_t b;
    imm_t   imm;
    int     i;
    begin
      a = rand_addr(4);
      for (i = 0; i < 4; i++) fill_line(a + paddr_t'(16 * i), 1'b1);
      // Sizes DW, W, H, B on four consecutive lines
      for (i = 0; i < 4; i++) begin
        imm = imm_t'($urandom);
        b   = a + paddr_t'(16 * i + (1 << (3 - i)));
        issue(i, OP_LOAD, lsu_size_e'(3 - i), i[0], {$urandom, b - sext_imm(imm)}, imm,
              rand_rd());
      end
      drain_and_check(4);
      fill_line(a, 1'b1);
      imm = imm_t'($urandom);
      issue(0, OP_LOAD, SIZE_W, 1'b1, {$urandom, a - sext_imm(imm)}, imm, '0);  // rd 0
      drain_and_check(1);
      end_test("back to back");
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'h5a66));
    n_tests        = 0;
    n_checks       = 0;
    n_errors       = 0;
    test_errors    = 0;
    reset_n        = 1'b0;
    issue_valid    = 1'b0;
    issue_op       = OP_LOAD;
    issue_size     = SIZE_B;
    issue_sign     = 1'b0;
    issue_rs1      = '0;
    issue_imm      = '0;
    issue_rd_valid = 1'b0;
    issue_rd_rnid  = '0;
    sq_en          = 1'b0;
    sq_addr        = '0;
    sq_mask        = '0;
    sq_data        = '0;
    for (i = 0; i < 16; i++) begin
      cache_present[i] = 1'b0;
      cache_tag[i]     = '0;
      cache_data[i]    = {$urandom, $urandom, $urandom, $urandom};
    end

    check_reset();
    test_cache_loads();
    test_stores();
    test_misalign();
    test_forwarding();
    test_back_to_back();

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
